//--- Bender.yml
package:
  name: book_update

sources:
  # Package first, then leaf blocks, then the top level
  - src/book_pkg.sv
  - src/book_state_ram.sv
  - src/book_update_fetch.sv
  - src/book_level_exe.sv
  - src/book_update_retire.sv
  - src/book_update.sv

  - target: simulation
    files:
      - testbench/tb_book_update.sv

//--- book_update.f
src/book_pkg.sv
src/book_state_ram.sv
src/book_update_fetch.sv
src/book_level_exe.sv
src/book_update_retire.sv
src/book_update.sv
testbench/tb_book_update.sv

//--- src/book_level_exe.sv
//====================
// Price level execute
// Applies add, remove or clear to one sorted list
// and flags a change of level 0
//====================

`timescale 1ns/1ps

module book_level_exe (
    input  book_pkg::cmd_t     i_cmd
  , input  book_pkg::key_t     i_key
  , input  book_pkg::volume_t  i_size
  , input  book_pkg::state_t   i_state
  , output book_pkg::state_t   o_state_nxt
  , output logic               o_notify
  , output book_pkg::key_t     o_lv0_key
  , output book_pkg::volume_t  o_lv0_size
);

  import book_pkg::*;

  logic [ENTRIES_N-1:0] cur_vld;
  key_t                 cur_key [ENTRIES_N];
  volume_t              cur_vol [ENTRIES_N];
  logic [ENTRIES_N-1:0] nxt_vld;
  key_t                 nxt_key [ENTRIES_N];
  volume_t              nxt_vol [ENTRIES_N];
  logic [ENTRIES_N-1:0] hit;
  logic [ENTRIES_N-1:0] below;
  logic [ENTRIES_N-1:0] ins_at;
  logic [ENTRIES_N-1:0] del_pfx;
  volume_t              hit_vol;
  logic                 rm_full;

  // Lane decode and per-lane compares
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      cur_vld[i] = i_state[VLD_LSB + i];
      cur_key[i] = i_state[KEY_LSB + i*KEY_BITS +: KEY_BITS];
      cur_vol[i] = i_state[VOL_LSB + i*VOLUME_BITS +: VOLUME_BITS];
      hit[i]     = cur_vld[i] & (cur_key[i] == i_key);
      below[i]   = cur_vld[i] & (cur_key[i] < i_key);
    end
  end

  // Insertion point is the first lane not below the key,
  // delete mask covers the hit lane and everything above
  always_comb begin
    hit_vol = '0;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (hit[i]) hit_vol = cur_vol[i];
    end
    rm_full    = (i_size >= hit_vol);
    ins_at[0]  = ~below[0];
    del_pfx[0] = hit[0] & rm_full;
    for (int i = 1; i < ENTRIES_N; i++) begin
      ins_at[i]  = ~below[i] & below[i-1];
      del_pfx[i] = del_pfx[i-1] | (hit[i] & rm_full);
    end
  end

  always_comb begin
    nxt_vld = cur_vld;
    nxt_key = cur_key;
    nxt_vol = cur_vol;
    case (i_cmd)
      CMD_ADD: begin
        if (|hit) begin
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (hit[i]) nxt_vol[i] = cur_vol[i] + i_size;
          end
        end else begin
          // Shift up above the insertion point, top lane falls off
          for (int i = 1; i < ENTRIES_N; i++) begin
            if (~below[i] & ~ins_at[i]) begin
              nxt_vld[i] = cur_vld[i-1];
              nxt_key[i] = cur_key[i-1];
              nxt_vol[i] = cur_vol[i-1];
            end
          end
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (ins_at[i]) begin
              nxt_vld[i] = 1'b1;
              nxt_key[i] = i_key;
              nxt_vol[i] = i_size;
            end
          end
        end
      end
      CMD_REMOVE: begin
        if (|hit & rm_full) begin
          // Shift down over the deleted level
          for (int i = 0; i < ENTRIES_N - 1; i++) begin
            if (del_pfx[i]) begin
              nxt_vld[i] = cur_vld[i+1];
              nxt_key[i] = cur_key[i+1];
              nxt_vol[i] = cur_vol[i+1];
            end
          end
          nxt_vld[ENTRIES_N-1] = 1'b0;
          nxt_key[ENTRIES_N-1] = '0;
          nxt_vol[ENTRIES_N-1] = '0;
        end else begin
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (hit[i]) nxt_vol[i] = cur_vol[i] - i_size;
          end
        end
      end
      CMD_CLEAR: begin
        nxt_vld = '0;
        nxt_key = '{default: '0};
        nxt_vol = '{default: '0};
      end
      default: begin
      end
    endcase
  end

  // Repack
  always_comb begin
    for (int i = 0; i < ENTRIES_N; i++) begin
      o_state_nxt[VLD_LSB + i]                          = nxt_vld[i];
      o_state_nxt[KEY_LSB + i*KEY_BITS +: KEY_BITS]      = nxt_key[i];
      o_state_nxt[VOL_LSB + i*VOLUME_BITS +: VOLUME_BITS] = nxt_vol[i];
    end
  end

  // Level 0 change, empty list reports zeros
  assign o_notify   = (nxt_vld[0] != cur_vld[0]) | (nxt_key[0] != cur_key[0]) |
                      (nxt_vol[0] != cur_vol[0]);
  assign o_lv0_key  = nxt_vld[0] ? nxt_key[0] : '0;
  assign o_lv0_size = nxt_vld[0] ? nxt_vol[0] : '0;

endmodule

//--- src/book_pkg.sv
//====================
// Order book package
// Sizes, vector types and command encoding shared by the update
// pipeline and its state table
//====================

package book_pkg;

  // Table and list sizes
  localparam int PRODUCTS_N  = 16;
  localparam int ENTRIES_N   = 4;
  localparam int KEY_BITS    = 16;
  localparam int VOLUME_BITS = 16;
  localparam int ID_BITS     = $clog2(PRODUCTS_N);

  // Packed list layout, lowest bits first
  // valid lanes, then key lanes, then volume lanes
  localparam int VLD_LSB    = 0;
  localparam int KEY_LSB    = VLD_LSB + ENTRIES_N;
  localparam int VOL_LSB    = KEY_LSB + ENTRIES_N * KEY_BITS;
  localparam int STATE_BITS = VOL_LSB + ENTRIES_N * VOLUME_BITS;

  // Product id, also the table address
  typedef logic [ID_BITS-1:0] id_t;

  // Price key
  typedef logic [KEY_BITS-1:0] key_t;

  // Update size and stored level volume
  typedef logic [VOLUME_BITS-1:0] volume_t;

  // One product's whole price-level list
  typedef logic [STATE_BITS-1:0] state_t;

  // Update commands
  typedef enum logic [1:0] {
    CMD_ADD    = 2'd0,
    CMD_REMOVE = 2'd1,
    CMD_CLEAR  = 2'd2
  } cmd_t;

endpackage

//--- src/book_state_ram.sv
//====================
// Book state table
// One packed list per product, registered read port,
// write port fed from the pipeline writeback
//====================

`timescale 1ns/1ps

module book_state_ram (
  // Read port
    input  logic              i_ren
  , input  book_pkg::id_t     i_raddr
  , output book_pkg::state_t  o_rdata
  // Write port
  , input  logic              i_wen
  , input  book_pkg::id_t     i_waddr
  , input  book_pkg::state_t  i_wdata
  // Clock and reset
  , input  logic              clk
  , input  logic              rst
);

  import book_pkg::*;

  state_t mem [PRODUCTS_N];

  // Writes, reset empties every list
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < PRODUCTS_N; i++) begin
        mem[i] <= '0;
      end
    end else if (i_wen) begin
      mem[i_waddr] <= i_wdata;
    end
  end

  // Registered read, same-address write returns old data
  always_ff @(posedge clk) begin
    if (i_ren) begin
      o_rdata <= mem[i_raddr];
    end
  end

endmodule

//--- src/book_update.sv
//====================
// Order book update pipeline
// State table, fetch stages and retire stage
//====================

`timescale 1ns/1ps

module book_update (
    input  logic               clk
  , input  logic               rst
  // Update bus
  , input  logic               i_upd_vld
  , input  book_pkg::id_t      i_upd_prod_id
  , input  book_pkg::cmd_t     i_upd_cmd
  , input  book_pkg::key_t     i_upd_key
  , input  book_pkg::volume_t  i_upd_size
  // Notify bus
  , output logic               o_lv0_vld
  , output book_pkg::id_t      o_lv0_prod_id
  , output book_pkg::key_t     o_lv0_key
  , output book_pkg::volume_t  o_lv0_size
);

  import book_pkg::*;

  // Table read
  logic    ram_ren;
  id_t     ram_raddr;
  state_t  ram_rdata;

  // S3 contents and execute result
  logic    s3_vld;
  id_t     s3_prod_id;
  cmd_t    s3_cmd;
  key_t    s3_key;
  volume_t s3_size;
  state_t  s3_state;
  state_t  s3_state_nxt;

  // Writeback, also the table write port
  logic    wrbk_vld;
  id_t     wrbk_prod_id;
  state_t  wrbk_state;

  book_state_ram u_book_state_ram (
      .i_ren   (ram_ren)
    , .i_raddr (ram_raddr)
    , .o_rdata (ram_rdata)
    , .i_wen   (wrbk_vld)
    , .i_waddr (wrbk_prod_id)
    , .i_wdata (wrbk_state)
    , .clk     (clk)
    , .rst     (rst)
  );

  book_update_fetch u_book_update_fetch (
      .i_upd_vld      (i_upd_vld)
    , .i_upd_prod_id  (i_upd_prod_id)
    , .i_upd_cmd      (i_upd_cmd)
    , .i_upd_key      (i_upd_key)
    , .i_upd_size     (i_upd_size)
    , .o_state_ren    (ram_ren)
    , .o_state_raddr  (ram_raddr)
    , .i_state_rdata  (ram_rdata)
    , .i_wrbk_vld     (wrbk_vld)
    , .i_wrbk_prod_id (wrbk_prod_id)
    , .i_wrbk_state   (wrbk_state)
    , .i_s3_vld       (s3_vld)
    , .i_s3_prod_id   (s3_prod_id)
    , .i_s3_state_nxt (s3_state_nxt)
    , .o_s3_vld       (s3_vld)
    , .o_s3_prod_id   (s3_prod_id)
    , .o_s3_cmd       (s3_cmd)
    , .o_s3_key       (s3_key)
    , .o_s3_size      (s3_size)
    , .o_s3_state     (s3_state)
    , .clk            (clk)
    , .rst            (rst)
  );

  book_update_retire u_book_update_retire (
      .i_s3_vld       (s3_vld)
    , .i_s3_prod_id   (s3_prod_id)
    , .i_s3_cmd       (s3_cmd)
    , .i_s3_key       (s3_key)
    , .i_s3_size      (s3_size)
    , .i_s3_state     (s3_state)
    , .o_s3_state_nxt (s3_state_nxt)
    , .o_wrbk_vld     (wrbk_vld)
    , .o_wrbk_prod_id (wrbk_prod_id)
    , .o_wrbk_state   (wrbk_state)
    , .o_lv0_vld      (o_lv0_vld)
    , .o_lv0_prod_id  (o_lv0_prod_id)
    , .o_lv0_key      (o_lv0_key)
    , .o_lv0_size     (o_lv0_size)
    , .clk            (clk)
    , .rst            (rst)
  );

endmodule

//--- src/book_update_fetch.sv
//====================
// Update fetch stages
// S1 issues the table read, S2 picks the freshest state
// from the execute stage, writeback, S1 capture or table
//====================

`timescale 1ns/1ps

module book_update_fetch (
  // Update bus
    input  logic                 i_upd_vld
  , input  book_pkg::id_t        i_upd_prod_id
  , input  book_pkg::cmd_t       i_upd_cmd
  , input  book_pkg::key_t       i_upd_key
  , input  book_pkg::volume_t    i_upd_size
  // Table read
  , output logic                 o_state_ren
  , output book_pkg::id_t        o_state_raddr
  , input  book_pkg::state_t     i_state_rdata
  // Forwarding sources
  , input  logic                 i_wrbk_vld
  , input  book_pkg::id_t        i_wrbk_prod_id
  , input  book_pkg::state_t     i_wrbk_state
  , input  logic                 i_s3_vld
  , input  book_pkg::id_t        i_s3_prod_id
  , input  book_pkg::state_t     i_s3_state_nxt
  // Into execute
  , output logic                 o_s3_vld
  , output book_pkg::id_t        o_s3_prod_id
  , output book_pkg::cmd_t       o_s3_cmd
  , output book_pkg::key_t       o_s3_key
  , output book_pkg::volume_t    o_s3_size
  , output book_pkg::state_t     o_s3_state
  // Clock and reset
  , input  logic                 clk
  , input  logic                 rst
);

  import book_pkg::*;

  // S1
  logic    s1_vld_r;
  id_t     s1_prod_id_r;
  cmd_t    s1_cmd_r;
  key_t    s1_key_r;
  volume_t s1_size_r;
  logic    s1_wrbk_hit;

  // S2
  logic    s2_vld_r;
  id_t     s2_prod_id_r;
  cmd_t    s2_cmd_r;
  key_t    s2_key_r;
  volume_t s2_size_r;
  logic    s2_cap_vld_r;
  state_t  s2_cap_state_r;
  logic    s2_s3_hit;
  logic    s2_wrbk_hit;
  state_t  s2_state_sel;

  // S3
  logic    s3_vld_r;
  id_t     s3_prod_id_r;
  cmd_t    s3_cmd_r;
  key_t    s3_key_r;
  volume_t s3_size_r;
  state_t  s3_state_r;

  always_ff @(posedge clk) begin
    if (rst) begin
      s1_vld_r <= 1'b0;
      s2_vld_r <= 1'b0;
      s3_vld_r <= 1'b0;
    end else begin
      s1_vld_r <= i_upd_vld;
      s2_vld_r <= s1_vld_r;
      s3_vld_r <= s2_vld_r;
    end
  end

  // S1 capture of the update
  always_ff @(posedge clk) begin
    if (i_upd_vld) begin
      s1_prod_id_r <= i_upd_prod_id;
      s1_cmd_r     <= i_upd_cmd;
      s1_key_r     <= i_upd_key;
      s1_size_r    <= i_upd_size;
    end
  end

  // Pending write to the same product lands with the read,
  // so take the writeback state and skip the read
  assign s1_wrbk_hit   = s1_vld_r & i_wrbk_vld & (i_wrbk_prod_id == s1_prod_id_r);
  assign o_state_ren   = s1_vld_r & ~s1_wrbk_hit;
  assign o_state_raddr = s1_prod_id_r;

  always_ff @(posedge clk) begin
    if (s1_vld_r) begin
      s2_prod_id_r   <= s1_prod_id_r;
      s2_cmd_r       <= s1_cmd_r;
      s2_key_r       <= s1_key_r;
      s2_size_r      <= s1_size_r;
      s2_cap_vld_r   <= s1_wrbk_hit;
      s2_cap_state_r <= i_wrbk_state;
    end
  end

  // Newest copy wins
  assign s2_s3_hit   = i_s3_vld & (i_s3_prod_id == s2_prod_id_r);
  assign s2_wrbk_hit = i_wrbk_vld & (i_wrbk_prod_id == s2_prod_id_r);

  always_comb begin
    if (s2_s3_hit) begin
      s2_state_sel = i_s3_state_nxt;
    end else if (s2_wrbk_hit) begin
      s2_state_sel = i_wrbk_state;
    end else if (s2_cap_vld_r) begin
      s2_state_sel = s2_cap_state_r;
    end else begin
      // Table data arrives last in the cone
      s2_state_sel = i_state_rdata;
    end
  end

  always_ff @(posedge clk) begin
    if (s2_vld_r) begin
      s3_prod_id_r <= s2_prod_id_r;
      s3_cmd_r     <= s2_cmd_r;
      s3_key_r     <= s2_key_r;
      s3_size_r    <= s2_size_r;
      s3_state_r   <= s2_state_sel;
    end
  end

  assign o_s3_vld     = s3_vld_r;
  assign o_s3_prod_id = s3_prod_id_r;
  assign o_s3_cmd     = s3_cmd_r;
  assign o_s3_key     = s3_key_r;
  assign o_s3_size    = s3_size_r;
  assign o_s3_state   = s3_state_r;

endmodule

//--- src/book_update_retire.sv
//====================
// Update retire stage
// Executes the S3 update, then registers the writeback
// and the level 0 notify
//====================

`timescale 1ns/1ps

module book_update_retire (
  // From fetch
    input  logic                 i_s3_vld
  , input  book_pkg::id_t        i_s3_prod_id
  , input  book_pkg::cmd_t       i_s3_cmd
  , input  book_pkg::key_t       i_s3_key
  , input  book_pkg::volume_t    i_s3_size
  , input  book_pkg::state_t     i_s3_state
  // Execute result, forwarded back to S2
  , output book_pkg::state_t     o_s3_state_nxt
  // Writeback, to table and forwarding
  , output logic                 o_wrbk_vld
  , output book_pkg::id_t        o_wrbk_prod_id
  , output book_pkg::state_t     o_wrbk_state
  // Notify bus
  , output logic                 o_lv0_vld
  , output book_pkg::id_t        o_lv0_prod_id
  , output book_pkg::key_t       o_lv0_key
  , output book_pkg::volume_t    o_lv0_size
  // Clock and reset
  , input  logic                 clk
  , input  logic                 rst
);

  import book_pkg::*;

  state_t  exe_state_nxt;
  logic    exe_notify;
  key_t    exe_lv0_key;
  volume_t exe_lv0_size;
  logic    lv0_load;

  book_level_exe u_book_level_exe (
      .i_cmd       (i_s3_cmd)
    , .i_key       (i_s3_key)
    , .i_size      (i_s3_size)
    , .i_state     (i_s3_state)
    , .o_state_nxt (exe_state_nxt)
    , .o_notify    (exe_notify)
    , .o_lv0_key   (exe_lv0_key)
    , .o_lv0_size  (exe_lv0_size)
  );

  assign o_s3_state_nxt = exe_state_nxt;

  // Notify only for valid updates that moved level 0
  assign lv0_load = i_s3_vld & exe_notify;

  always_ff @(posedge clk) begin
    if (rst) begin
      o_wrbk_vld <= 1'b0;
      o_lv0_vld  <= 1'b0;
    end else begin
      o_wrbk_vld <= i_s3_vld;
      o_lv0_vld  <= lv0_load;
    end
  end

  // Every valid update writes back, even if unchanged
  always_ff @(posedge clk) begin
    if (i_s3_vld) begin
      o_wrbk_prod_id <= i_s3_prod_id;
      o_wrbk_state   <= exe_state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (lv0_load) begin
      o_lv0_prod_id <= i_s3_prod_id;
      o_lv0_key     <= exe_lv0_key;
      o_lv0_size    <= exe_lv0_size;
    end
  end

endmodule

//--- testbench/tb_book_update.sv
//====================
// Order book update testbench
// Directed and random updates checked against a
// sorted-list reference model of every product
//====================

`timescale 1ns/1ps

module tb_book_update;

  import book_pkg::*;

  localparam int SEED       = 69661;
  localparam int DRAIN_MAX  = 64;
  localparam int NOTIFY_LAT = 4;

  logic    clk = 1'b0;
  logic    rst;
  logic    i_upd_vld;
  id_t     i_upd_prod_id;
  cmd_t    i_upd_cmd;
  key_t    i_upd_key;
  volume_t i_upd_size;
  logic    o_lv0_vld;
  id_t     o_lv0_prod_id;
  key_t    o_lv0_key;
  volume_t o_lv0_size;

  // Rising edge count used as the time base for due edges
  int      edge_cnt = 0;
  int      err_cnt  = 0;

  // Reference lists with invalid lanes kept at zero
  logic    m_vld [PRODUCTS_N][ENTRIES_N];
  key_t    m_key [PRODUCTS_N][ENTRIES_N];
  volume_t m_vol [PRODUCTS_N][ENTRIES_N];

  // Expected notifies in issue order
  id_t     exp_id  [$];
  key_t    exp_key [$];
  volume_t exp_vol [$];
  int      exp_due [$];

  book_update u_book_update (
      .clk           (clk)
    , .rst           (rst)
    , .i_upd_vld     (i_upd_vld)
    , .i_upd_prod_id (i_upd_prod_id)
    , .i_upd_cmd     (i_upd_cmd)
    , .i_upd_key     (i_upd_key)
    , .i_upd_size    (i_upd_size)
    , .o_lv0_vld     (o_lv0_vld)
    , .o_lv0_prod_id (o_lv0_prod_id)
    , .o_lv0_key     (o_lv0_key)
    , .o_lv0_size    (o_lv0_size)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    edge_cnt <= edge_cnt + 1;
  end

  task automatic check_id(input string name, input id_t got, input id_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_key(input string name, input key_t got, input key_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  task automatic check_volume(input string name, input volume_t got, input volume_t exp);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      err_cnt++;
    end
  endtask

  // Apply one update to the model and queue a notify if level 0 moved
  task automatic model_apply(input id_t id, input cmd_t cmd, input key_t key,
                             input volume_t size, input int due);
    logic    old_vld;
    key_t    old_key;
    volume_t old_vol;
    int      hit_idx;
    int      pos;
    old_vld = m_vld[id][0];
    old_key = m_key[id][0];
    old_vol = m_vol[id][0];
    hit_idx = -1;
    for (int i = 0; i < ENTRIES_N; i++) begin
      if (m_vld[id][i] && m_key[id][i] == key) hit_idx = i;
    end
    case (cmd)
      CMD_ADD: begin
        if (hit_idx >= 0) begin
          m_vol[id][hit_idx] = m_vol[id][hit_idx] + size;
        end else begin
          // Count of levels below the new key is its slot
          pos = 0;
          for (int i = 0; i < ENTRIES_N; i++) begin
            if (m_vld[id][i] && m_key[id][i] < key) pos++;
          end
          if (pos < ENTRIES_N) begin
            for (int i = ENTRIES_N - 1; i > pos; i--) begin
              m_vld[id][i] = m_vld[id][i-1];
              m_key[id][i] = m_key[id][i-1];
              m_vol[id][i] = m_vol[id][i-1];
            end
            m_vld[id][pos] = 1'b1;
            m_key[id][pos] = key;
            m_vol[id][pos] = size;
          end
        end
      end
      CMD_REMOVE: begin
        if (hit_idx >= 0 && size >= m_vol[id][hit_idx]) begin
          for (int i = hit_idx; i < ENTRIES_N - 1; i++) begin
            m_vld[id][i] = m_vld[id][i+1];
            m_key[id][i] = m_key[id][i+1];
            m_vol[id][i] = m_vol[id][i+1];
          end
          m_vld[id][ENTRIES_N-1] = 1'b0;
          m_key[id][ENTRIES_N-1] = '0;
          m_vol[id][ENTRIES_N-1] = '0;
        end else if (hit_idx >= 0) begin
          m_vol[id][hit_idx] = m_vol[id][hit_idx] - size;
        end
      end
      default: begin
        for (int i = 0; i < ENTRIES_N; i++) begin
          m_vld[id][i] = 1'b0;
          m_key[id][i] = '0;
          m_vol[id][i] = '0;
        end
      end
    endcase
    if (old_vld != m_vld[id][0] || old_key != m_key[id][0] || old_vol != m_vol[id][0]) begin
      exp_id.push_back(id);
      exp_key.push_back(m_key[id][0]);
      exp_vol.push_back(m_vol[id][0]);
      exp_due.push_back(due);
    end
  endtask

  // Drive one update and hold valid until the next drive
  task automatic issue(input id_t id, input cmd_t cmd, input key_t key, input volume_t size);
    @(posedge clk);
    #1;
    i_upd_vld     = 1'b1;
    i_upd_prod_id = id;
    i_upd_cmd     = cmd;
    i_upd_key     = key;
    i_upd_size    = size;
    model_apply(id, cmd, key, size, edge_cnt + NOTIFY_LAT);
  endtask

  task automatic idle(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
      i_upd_vld = 1'b0;
    end
  endtask

  task automatic wait_drain();
    int cnt;
    cnt = 0;
    idle(1);
    while (exp_due.size() != 0 && cnt < DRAIN_MAX) begin
      @(posedge clk);
      cnt++;
    end
    if (exp_due.size() != 0) begin
      $display("Timed out with %0d notifies still outstanding", exp_due.size());
      err_cnt++;
    end
  endtask

  // Notify monitor sampling mid-cycle
  always @(negedge clk) begin
    if (!rst) begin
      if (o_lv0_vld) begin
        if (exp_due.size() == 0) begin
          $display("Notify for product %0d with nothing pending at edge %0d",
                   o_lv0_prod_id, edge_cnt);
          err_cnt++;
        end else begin
          if (exp_due[0] != edge_cnt) begin
            $display("Notify seen at edge %0d but due at edge %0d", edge_cnt, exp_due[0]);
            err_cnt++;
          end
          check_id("o_lv0_prod_id", o_lv0_prod_id, exp_id[0]);
          check_key("o_lv0_key", o_lv0_key, exp_key[0]);
          check_volume("o_lv0_size", o_lv0_size, exp_vol[0]);
          void'(exp_id.pop_front());
          void'(exp_key.pop_front());
          void'(exp_vol.pop_front());
          void'(exp_due.pop_front());
        end
      end else if (exp_due.size() != 0 && exp_due[0] < edge_cnt) begin
        $display("Missing notify for product %0d due at edge %0d", exp_id[0], exp_due[0]);
        err_cnt++;
        void'(exp_id.pop_front());
        void'(exp_key.pop_front());
        void'(exp_vol.pop_front());
        void'(exp_due.pop_front());
      end
    end
  end

  task automatic reset_then_first_add();
    idle(20);
    issue(4'd1, CMD_ADD, 16'h0100, 16'h0010);
    wait_drain();
  endtask

  task automatic sorted_insertion();
    issue(4'd2, CMD_ADD, 16'h0200, 16'h0005);
    idle(6);
    // Above level 0 so no notify
    issue(4'd2, CMD_ADD, 16'h0300, 16'h0007);
    idle(6);
    issue(4'd2, CMD_ADD, 16'h0100, 16'h0003);
    idle(6);
    // Same key again sums the volumes
    issue(4'd2, CMD_ADD, 16'h0100, 16'h0004);
    wait_drain();
  endtask

  task automatic level_removal();
    issue(4'd3, CMD_ADD, 16'h0010, 16'd20);
    issue(4'd3, CMD_ADD, 16'h0020, 16'd30);
    issue(4'd3, CMD_ADD, 16'h0030, 16'd40);
    idle(6);
    issue(4'd3, CMD_REMOVE, 16'h0010, 16'd5);
    idle(6);
    // Full removal moves 0x20 down
    issue(4'd3, CMD_REMOVE, 16'h0010, 16'd15);
    idle(6);
    issue(4'd3, CMD_REMOVE, 16'h0055, 16'd1);
    idle(6);
    issue(4'd3, CMD_REMOVE, 16'h0030, 16'd10);
    wait_drain();
  endtask

  task automatic overflow_and_clear();
    issue(4'd4, CMD_ADD, 16'h0040, 16'd1);
    issue(4'd4, CMD_ADD, 16'h0010, 16'd2);
    issue(4'd4, CMD_ADD, 16'h0030, 16'd3);
    issue(4'd4, CMD_ADD, 16'h0020, 16'd4);
    // Full list drops the new key as the highest
    issue(4'd4, CMD_ADD, 16'h0050, 16'd5);
    // Lowest key pushes 0x40 out
    issue(4'd4, CMD_ADD, 16'h0005, 16'd6);
    idle(6);
    issue(4'd4, CMD_REMOVE, 16'h0005, 16'd6);
    issue(4'd4, CMD_REMOVE, 16'h0010, 16'd2);
    issue(4'd4, CMD_REMOVE, 16'h0020, 16'd4);
    issue(4'd4, CMD_REMOVE, 16'h0030, 16'd3);
    wait_drain();
    issue(4'd4, CMD_ADD, 16'h0070, 16'd9);
    issue(4'd4, CMD_ADD, 16'h0060, 16'd8);
    idle(6);
    issue(4'd4, CMD_CLEAR, 16'h0000, 16'd0);
    idle(6);
    // Already empty
    issue(4'd4, CMD_CLEAR, 16'h0000, 16'd0);
    wait_drain();
  endtask

  // Gaps 0 to 4 hit S3, writeback, S1 capture and table paths
  task automatic same_product_gaps();
    for (int g = 0; g <= 4; g++) begin
      issue(4'd8, CMD_ADD, 16'h0080, 16'd1);
      idle(g);
      issue(4'd8, CMD_ADD, 16'h0080, 16'd2);
      idle(g);
      issue(4'd8, CMD_ADD, 16'h0070, 16'd4);
      idle(g);
      issue(4'd8, CMD_REMOVE, 16'h0070, 16'd4);
      idle(g);
      issue(4'd8, CMD_REMOVE, 16'h0080, 16'd3);
      wait_drain();
    end
  endtask

  task automatic random_stream();
    id_t     id;
    cmd_t    cmd;
    key_t    key;
    volume_t size;
    int      r;
    for (int n = 0; n < 200; n++) begin
      id = id_t'(10 + $urandom_range(0, 2));
      r  = $urandom_range(0, 9);
      if (r < 5) cmd = CMD_ADD;
      else if (r < 9) cmd = CMD_REMOVE;
      else cmd = CMD_CLEAR;
      key  = key_t'($urandom_range(1, 6));
      size = volume_t'($urandom_range(1, 5));
      issue(id, cmd, key, size);
      idle($urandom_range(0, 3));
    end
    wait_drain();
  endtask

  initial begin
    void'($urandom(SEED));
    for (int p = 0; p < PRODUCTS_N; p++) begin
      for (int i = 0; i < ENTRIES_N; i++) begin
        m_vld[p][i] = 1'b0;
        m_key[p][i] = '0;
        m_vol[p][i] = '0;
      end
    end
    rst           = 1'b1;
    i_upd_vld     = 1'b0;
    i_upd_prod_id = '0;
    i_upd_cmd     = CMD_ADD;
    i_upd_key     = '0;
    i_upd_size    = '0;
    repeat (16) @(posedge clk);
    #1;
    rst = 1'b0;
    reset_then_first_add();
    sorted_insertion();
    level_removal();
    overflow_and_clear();
    same_product_gaps();
    random_stream();
    // Quiet tail catches stray strobes
    idle(10);
    $display("Error count: %0d", err_cnt);
    if (err_cnt == 0) begin
      $display("No errors");
    end else begin
      $display("Errors found");
    end
    $finish;
  end

endmodule
